/* src/dfdCsrPkg.sv */
// Bus width types, access and region enums, byte strobe merge helper
package dfdCsrPkg;

    localparam int ApbAddrWidth  = 23;
    localparam int ApbDataWidth  = 32;
    localparam int ApbStrbWidth  = ApbDataWidth / 8;
    localparam int RegOffsetWidth = 12;

    typedef logic [ApbAddrWidth-1:0]   apbAddr_t;
    typedef logic [ApbDataWidth-1:0]   apbData_t;
    typedef logic [ApbStrbWidth-1:0]   apbStrb_t;
    typedef logic [RegOffsetWidth-1:0] regOffset_t;

    // APB access sequencer
    typedef enum logic [1:0] {
        AccessIdle,
        AccessWait,
        AccessReady
    } accessState_t;

    typedef enum logic [1:0] {
        RegionNone,
        RegionMcr,
        RegionDst,
        RegionTr
    } regionSel_t;

    // Replace the bytes of oldVal that are enabled in strb
    function automatic apbData_t strobeMerge(apbData_t oldVal, apbData_t newVal,
                                             apbStrb_t strb);
        apbData_t merged;
        merged = oldVal;
        for (int b = 0; b < ApbStrbWidth; b++) begin
            if (strb[b]) begin
                merged[b*8 +: 8] = newVal[b*8 +: 8];
            end
        end
        return merged;
    endfunction

endpackage

/* src/dfdMapPkg.sv */
// Address map of the debug register block with region bases, register offsets,
// fixed implementation words and the trace RAM size
package dfdMapPkg;

    // ------------------------------------------------------------------------
    // Region bases relative to the block base address
    // ------------------------------------------------------------------------
    localparam int unsigned McrRegionBase = 'h0000;
    localparam int unsigned DstRegionBase = 'h2000;
    localparam int unsigned TrRegionBase  = 'h4000;

    // Every region covers the same window
    localparam int unsigned RegionSpan = 'h1000;

    // ------------------------------------------------------------------------
    // Register offsets within each region
    // ------------------------------------------------------------------------
    // MCR
    localparam int unsigned McrDbgMuxSelOffset = 'h000;
    localparam int unsigned McrDfdCsrOffset    = 'h008;

    // DST
    localparam int unsigned DstControlOffset  = 'h000;
    localparam int unsigned DstImplOffset     = 'h004;
    localparam int unsigned DstTraceCfgOffset = 'h008;

    // Trace sink
    localparam int unsigned TrRamControlOffset   = 'h000;
    localparam int unsigned TrRamStartLowOffset  = 'h010;
    localparam int unsigned TrRamStartHighOffset = 'h014;
    localparam int unsigned TrRamLimitLowOffset  = 'h018;
    localparam int unsigned TrRamLimitHighOffset = 'h01C;
    localparam int unsigned TrScratchLoOffset    = 'h030;
    localparam int unsigned TrScratchHiOffset    = 'h034;

    // ------------------------------------------------------------------------
    // Fixed values
    // ------------------------------------------------------------------------
    // Read-only DST implementation word
    localparam int unsigned DstImplValue = 'h0001_0021;

    // Trace RAM size in bytes and upper bound for start/limit in SRAM mode
    localparam int unsigned TraceRamSize = 'h8000;

endpackage

/* src/dfdApbDecode.sv */
// APB access sequencer with setup phase capture, access state machine and
// region decode into a region select plus in-region offset
`timescale 1ns/1ps

module dfdApbDecode
    import dfdCsrPkg::*;
    import dfdMapPkg::*;
#(
    parameter apbAddr_t BaseAddr = '0
) (
    input  logic       clk,
    input  logic       reset,
    input  apbAddr_t   paddr,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apbData_t   pwdata,
    input  apbStrb_t   pstrb,
    output logic       pready,
    output logic       accessEn,
    output logic       accessWrite,
    output regionSel_t region,
    output regOffset_t offset,
    output apbData_t   wrData,
    output apbStrb_t   wrStrb
);

    accessState_t state;
    accessState_t stateNext;
    logic         setupPhase;
    apbAddr_t     relAddr;
    apbAddr_t     regionBase;
    regionSel_t   regionNext;

    assign setupPhase = (state == AccessIdle) && psel && !penable;

    // ------------------------------------------------------------------------
    // Access state machine
    // ------------------------------------------------------------------------
    always_comb begin
        stateNext = state;
        case (state)
            AccessIdle: begin
                if (setupPhase) begin
                    stateNext = AccessWait;
                end
            end
            AccessWait: begin
                // Master dropped psel so the transfer is abandoned silently
                if (!psel) begin
                    stateNext = AccessIdle;
                end else if (penable) begin
                    stateNext = AccessReady;
                end
            end
            AccessReady: stateNext = AccessIdle;
            default:     stateNext = AccessIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= AccessIdle;
        end else begin
            state <= stateNext;
        end
    end

    assign accessEn = (state == AccessWait) && psel && penable;
    assign pready   = (state == AccessReady);

    // ------------------------------------------------------------------------
    // Region decode
    // ------------------------------------------------------------------------
    always_comb begin
        relAddr    = paddr - BaseAddr;
        regionNext = RegionNone;
        regionBase = '0;
        if (relAddr >= McrRegionBase && relAddr < McrRegionBase + RegionSpan) begin
            regionNext = RegionMcr;
            regionBase = apbAddr_t'(McrRegionBase);
        end else if (relAddr >= DstRegionBase && relAddr < DstRegionBase + RegionSpan) begin
            regionNext = RegionDst;
            regionBase = apbAddr_t'(DstRegionBase);
        end else if (relAddr >= TrRegionBase && relAddr < TrRegionBase + RegionSpan) begin
            regionNext = RegionTr;
            regionBase = apbAddr_t'(TrRegionBase);
        end
    end

    // Transfer attributes held for the access phase
    always_ff @(posedge clk) begin
        if (setupPhase) begin
            region      <= regionNext;
            offset      <= regOffset_t'(relAddr - regionBase);
            accessWrite <= pwrite;
            wrData      <= pwdata;
            wrStrb      <= pstrb;
        end
    end

endmodule

/* src/dfdCtrlCsrs.sv */
// MCR and DST register bank with mux select, DFD control, DST control,
// DST trace config and the read-only DST implementation word
`timescale 1ns/1ps

module dfdCtrlCsrs
    import dfdCsrPkg::*;
    import dfdMapPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       accessEn,
    input  logic       accessWrite,
    input  regionSel_t region,
    input  regOffset_t offset,
    input  apbData_t   wrData,
    input  apbStrb_t   wrStrb,
    output logic       hit,
    output apbData_t   rdData,
    output apbData_t   dbgMuxSel,
    output apbData_t   dstControl
);

    apbData_t dfdCsr;
    apbData_t dstTraceCfg;
    logic     wrEn;

    // ------------------------------------------------------------------------
    // Read decode
    // ------------------------------------------------------------------------
    always_comb begin
        hit    = 1'b0;
        rdData = '0;
        case (region)
            RegionMcr: begin
                case (offset)
                    McrDbgMuxSelOffset: begin
                        hit    = 1'b1;
                        rdData = dbgMuxSel;
                    end
                    McrDfdCsrOffset: begin
                        hit    = 1'b1;
                        rdData = dfdCsr;
                    end
                    default: ;
                endcase
            end
            RegionDst: begin
                case (offset)
                    DstControlOffset: begin
                        hit    = 1'b1;
                        rdData = dstControl;
                    end
                    DstImplOffset: begin
                        hit    = 1'b1;
                        rdData = apbData_t'(DstImplValue);
                    end
                    DstTraceCfgOffset: begin
                        hit    = 1'b1;
                        rdData = dstTraceCfg;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    assign wrEn = accessEn && accessWrite && hit;

    // Impl word has no storage and ignores writes
    always_ff @(posedge clk) begin
        if (reset) begin
            dbgMuxSel   <= '0;
            dfdCsr      <= '0;
            dstControl  <= '0;
            dstTraceCfg <= '0;
        end else if (wrEn) begin
            if (region == RegionMcr && offset == McrDbgMuxSelOffset) begin
                dbgMuxSel <= strobeMerge(dbgMuxSel, wrData, wrStrb);
            end
            if (region == RegionMcr && offset == McrDfdCsrOffset) begin
                dfdCsr <= strobeMerge(dfdCsr, wrData, wrStrb);
            end
            if (region == RegionDst && offset == DstControlOffset) begin
                dstControl <= strobeMerge(dstControl, wrData, wrStrb);
            end
            if (region == RegionDst && offset == DstTraceCfgOffset) begin
                dstTraceCfg <= strobeMerge(dstTraceCfg, wrData, wrStrb);
            end
        end
    end

endmodule

/* src/dfdTraceRamCsrs.sv */
// Trace sink register bank holding RAM control, start/limit words with WARL
// legalization in SRAM mode and two scratch words
`timescale 1ns/1ps

module dfdTraceRamCsrs
    import dfdCsrPkg::*;
    import dfdMapPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       accessEn,
    input  logic       accessWrite,
    input  regionSel_t region,
    input  regOffset_t offset,
    input  apbData_t   wrData,
    input  apbStrb_t   wrStrb,
    output logic       hit,
    output apbData_t   rdData,
    output logic       traceRamMode,
    output apbData_t   traceRamStart,
    output apbData_t   traceRamLimit
);

    apbData_t ramControl;
    apbData_t startLow;
    apbData_t startHigh;
    apbData_t limitLow;
    apbData_t limitHigh;
    apbData_t scratchLo;
    apbData_t scratchHi;
    logic     sramMode;
    logic     wrEn;

    // Low words may not point past the end of the local trace RAM
    function automatic apbData_t warlLow(apbData_t merged, logic clampEn);
        apbData_t legal;
        legal = merged;
        if (clampEn && merged > TraceRamSize) begin
            legal = apbData_t'(TraceRamSize);
        end
        return legal;
    endfunction

    // Mode bit 0 selects SRAM
    assign sramMode      = ~ramControl[0];
    assign traceRamMode  = ramControl[0];
    assign traceRamStart = startLow;
    assign traceRamLimit = limitLow;

    // ------------------------------------------------------------------------
    // Read decode
    // ------------------------------------------------------------------------
    always_comb begin
        hit    = (region == RegionTr);
        rdData = '0;
        case (offset)
            TrRamControlOffset:   rdData = ramControl;
            TrRamStartLowOffset:  rdData = startLow;
            TrRamStartHighOffset: rdData = startHigh;
            TrRamLimitLowOffset:  rdData = limitLow;
            TrRamLimitHighOffset: rdData = limitHigh;
            TrScratchLoOffset:    rdData = scratchLo;
            TrScratchHiOffset:    rdData = scratchHi;
            default:              hit = 1'b0;
        endcase
        if (!hit) begin
            rdData = '0;
        end
    end

    assign wrEn = accessEn && accessWrite && hit;

    // ------------------------------------------------------------------------
    // Register writes
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ramControl <= '0;
            startLow   <= '0;
            startHigh  <= '0;
            limitLow   <= '0;
            limitHigh  <= '0;
            scratchLo  <= '0;
            scratchHi  <= '0;
        end else if (wrEn) begin
            case (offset)
                TrRamControlOffset: begin
                    ramControl <= strobeMerge(ramControl, wrData, wrStrb);
                end
                TrRamStartLowOffset: begin
                    startLow <= warlLow(strobeMerge(startLow, wrData, wrStrb), sramMode);
                end
                TrRamLimitLowOffset: begin
                    limitLow <= warlLow(strobeMerge(limitLow, wrData, wrStrb), sramMode);
                end
                // High words only exist for system memory
                TrRamStartHighOffset: begin
                    if (!sramMode) begin
                        startHigh <= strobeMerge(startHigh, wrData, wrStrb);
                    end
                end
                TrRamLimitHighOffset: begin
                    if (!sramMode) begin
                        limitHigh <= strobeMerge(limitHigh, wrData, wrStrb);
                    end
                end
                TrScratchLoOffset: scratchLo <= strobeMerge(scratchLo, wrData, wrStrb);
                TrScratchHiOffset: scratchHi <= strobeMerge(scratchHi, wrData, wrStrb);
                default: ;
            endcase
        end
    end

endmodule

/* src/dfdReadReturn.sv */
// Read return stage with bank read select, unclaimed address error and the
// registered APB read data and error response
`timescale 1ns/1ps

module dfdReadReturn
    import dfdCsrPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     accessEn,
    input  logic     accessWrite,
    input  logic     ctrlHit,
    input  apbData_t ctrlRdData,
    input  logic     trHit,
    input  apbData_t trRdData,
    output apbData_t prdata,
    output logic     pslverr
);

    logic     anyHit;
    apbData_t readWord;

    assign anyHit = ctrlHit | trHit;

    // Writes and errors return zero data
    always_comb begin
        readWord = '0;
        if (!accessWrite) begin
            if (ctrlHit) begin
                readWord = ctrlRdData;
            end else if (trHit) begin
                readWord = trRdData;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Response registers valid in the pready cycle
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else begin
            // Error lasts one cycle in step with pready
            pslverr <= accessEn & ~anyHit;
            if (accessEn) begin
                prdata <= readWord;
            end
        end
    end

endmodule

/* src/dfdMmrs.sv */
// Top level of the debug register block with APB decode, MCR/DST bank,
// trace sink bank and read return stage
`timescale 1ns/1ps

module dfdMmrs
    import dfdCsrPkg::*;
#(
    parameter apbAddr_t BaseAddr = '0
) (
    input  logic     clk,
    input  logic     reset,

    // APB slave
    input  apbAddr_t paddr,
    input  logic     psel,
    input  logic     penable,
    input  logic     pwrite,
    input  apbData_t pwdata,
    input  apbStrb_t pstrb,
    output logic     pready,
    output apbData_t prdata,
    output logic     pslverr,

    // Config outputs
    output apbData_t dbgMuxSel,
    output apbData_t dstControl,
    output logic     traceRamMode,
    output apbData_t traceRamStart,
    output apbData_t traceRamLimit
);

    logic       accessEn;
    logic       accessWrite;
    regionSel_t region;
    regOffset_t offset;
    apbData_t   wrData;
    apbStrb_t   wrStrb;
    logic       ctrlHit;
    apbData_t   ctrlRdData;
    logic       trHit;
    apbData_t   trRdData;

    dfdApbDecode #(
        .BaseAddr(BaseAddr)
    ) i_dfdApbDecode (
        .clk        (clk),
        .reset      (reset),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .pstrb      (pstrb),
        .pready     (pready),
        .accessEn   (accessEn),
        .accessWrite(accessWrite),
        .region     (region),
        .offset     (offset),
        .wrData     (wrData),
        .wrStrb     (wrStrb)
    );

    dfdCtrlCsrs i_dfdCtrlCsrs (
        .clk        (clk),
        .reset      (reset),
        .accessEn   (accessEn),
        .accessWrite(accessWrite),
        .region     (region),
        .offset     (offset),
        .wrData     (wrData),
        .wrStrb     (wrStrb),
        .hit        (ctrlHit),
        .rdData     (ctrlRdData),
        .dbgMuxSel  (dbgMuxSel),
        .dstControl (dstControl)
    );

    dfdTraceRamCsrs i_dfdTraceRamCsrs (
        .clk          (clk),
        .reset        (reset),
        .accessEn     (accessEn),
        .accessWrite  (accessWrite),
        .region       (region),
        .offset       (offset),
        .wrData       (wrData),
        .wrStrb       (wrStrb),
        .hit          (trHit),
        .rdData       (trRdData),
        .traceRamMode (traceRamMode),
        .traceRamStart(traceRamStart),
        .traceRamLimit(traceRamLimit)
    );

    dfdReadReturn i_dfdReadReturn (
        .clk        (clk),
        .reset      (reset),
        .accessEn   (accessEn),
        .accessWrite(accessWrite),
        .ctrlHit    (ctrlHit),
        .ctrlRdData (ctrlRdData),
        .trHit      (trHit),
        .trRdData   (trRdData),
        .prdata     (prdata),
        .pslverr    (pslverr)
    );

endmodule

/* dv/dfdMmrs_properties.sv */
// Concurrent checks on the APB response of the debug register block
// bound into its top level
`timescale 1ns/1ps

module dfdMmrs_properties (
    input logic clk,
    input logic reset,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr
);

    int failCount = 0;

    // pready only inside an access phase
    readyInAccess: assert property (
        @(posedge clk) disable iff (reset) pready |-> (psel && penable)
    ) else begin
        $error("pready raised outside an APB access phase");
        failCount++;
    end

    // One completion cycle per transfer
    readySingleCycle: assert property (
        @(posedge clk) disable iff (reset) pready |=> !pready
    ) else begin
        $error("pready held for two consecutive cycles");
        failCount++;
    end

    errorWithReady: assert property (
        @(posedge clk) disable iff (reset) pslverr |-> pready
    ) else begin
        $error("pslverr raised without pready");
        failCount++;
    end

endmodule

bind dfdMmrs dfdMmrs_properties i_dfdMmrsProperties (
    .clk    (clk),
    .reset  (reset),
    .psel   (psel),
    .penable(penable),
    .pready (pready),
    .pslverr(pslverr)
);

/* dv/dfdMmrsTb.sv */
// Testbench for the debug register block with register model, stimulus table,
// APB transfer and check tasks and the closing result line
`timescale 1ns/1ps

module dfdMmrsTb
    import dfdCsrPkg::*;
    import dfdMapPkg::*;
();

    localparam int ClkHalfPeriod = 20;
    localparam int ResetCycles   = 8;
    localparam int ReadyTimeout  = 20;
    localparam int SeedValue     = 44905;
    localparam int NumRegs       = 12;

    localparam apbAddr_t MuxSelAddr    = apbAddr_t'(McrRegionBase + McrDbgMuxSelOffset);
    localparam apbAddr_t DfdCsrAddr    = apbAddr_t'(McrRegionBase + McrDfdCsrOffset);
    localparam apbAddr_t DstCtrlAddr   = apbAddr_t'(DstRegionBase + DstControlOffset);
    localparam apbAddr_t DstImplAddr   = apbAddr_t'(DstRegionBase + DstImplOffset);
    localparam apbAddr_t DstCfgAddr    = apbAddr_t'(DstRegionBase + DstTraceCfgOffset);
    localparam apbAddr_t RamCtrlAddr   = apbAddr_t'(TrRegionBase + TrRamControlOffset);
    localparam apbAddr_t StartLowAddr  = apbAddr_t'(TrRegionBase + TrRamStartLowOffset);
    localparam apbAddr_t StartHighAddr = apbAddr_t'(TrRegionBase + TrRamStartHighOffset);
    localparam apbAddr_t LimitLowAddr  = apbAddr_t'(TrRegionBase + TrRamLimitLowOffset);
    localparam apbAddr_t LimitHighAddr = apbAddr_t'(TrRegionBase + TrRamLimitHighOffset);
    localparam apbAddr_t ScrLoAddr     = apbAddr_t'(TrRegionBase + TrScratchLoOffset);
    localparam apbAddr_t ScrHiAddr     = apbAddr_t'(TrRegionBase + TrScratchHiOffset);

    typedef struct {
        string    name;
        logic     write;
        apbAddr_t addr;
        apbData_t data;
        apbStrb_t strb;
        apbData_t expData;
        logic     expErr;
    } step_t;

    logic     clk;
    logic     reset;
    apbAddr_t paddr;
    logic     psel;
    logic     penable;
    logic     pwrite;
    apbData_t pwdata;
    apbStrb_t pstrb;
    logic     pready;
    apbData_t prdata;
    logic     pslverr;
    apbData_t dbgMuxSel;
    apbData_t dstControl;
    logic     traceRamMode;
    apbData_t traceRamStart;
    apbData_t traceRamLimit;

    apbAddr_t regAddrs [NumRegs] = '{MuxSelAddr, DfdCsrAddr, DstCtrlAddr, DstImplAddr,
                                     DstCfgAddr, RamCtrlAddr, StartLowAddr, StartHighAddr,
                                     LimitLowAddr, LimitHighAddr, ScrLoAddr, ScrHiAddr};
    apbData_t modelRegs [NumRegs];
    step_t    steps [$];
    int       errorCount;
    int       checkCount;

    dfdMmrs i_dfdMmrs (
        .clk          (clk),
        .reset        (reset),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .pstrb        (pstrb),
        .pready       (pready),
        .prdata       (prdata),
        .pslverr      (pslverr),
        .dbgMuxSel    (dbgMuxSel),
        .dstControl   (dstControl),
        .traceRamMode (traceRamMode),
        .traceRamStart(traceRamStart),
        .traceRamLimit(traceRamLimit)
    );

    always #ClkHalfPeriod clk = ~clk;

    // ------------------------------------------------------------------------
    // Register model
    // ------------------------------------------------------------------------
    function automatic int regIndex(apbAddr_t addr);
        int idx;
        idx = -1;
        for (int i = 0; i < NumRegs; i++) begin
            if (regAddrs[i] == addr) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic apbData_t modelRead(apbAddr_t addr);
        apbData_t value;
        int       idx;
        idx   = regIndex(addr);
        value = '0;
        if (addr == DstImplAddr) begin
            value = apbData_t'(DstImplValue);
        end else if (idx >= 0) begin
            value = modelRegs[idx];
        end
        return value;
    endfunction

    function automatic void modelWrite(apbAddr_t addr, apbData_t data, apbStrb_t strb);
        apbData_t merged;
        logic     sram;
        int       idx;
        idx  = regIndex(addr);
        sram = !modelRegs[regIndex(RamCtrlAddr)][0];
        if (idx < 0 || addr == DstImplAddr) begin
            return;
        end
        merged = modelRegs[idx];
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        // SRAM mode has no high address words
        if (sram && (addr == StartHighAddr || addr == LimitHighAddr)) begin
            return;
        end
        if (sram && (addr == StartLowAddr || addr == LimitLowAddr) && merged > TraceRamSize) begin
            merged = apbData_t'(TraceRamSize);
        end
        modelRegs[idx] = merged;
    endfunction

    // ------------------------------------------------------------------------
    // Table building and checking
    // ------------------------------------------------------------------------
    task automatic addStep(string name, logic write, apbAddr_t addr, apbData_t data,
                           apbStrb_t strb);
        step_t s;
        s.name    = name;
        s.write   = write;
        s.addr    = addr;
        s.data    = data;
        s.strb    = strb;
        s.expErr  = (regIndex(addr) < 0);
        s.expData = write ? '0 : modelRead(addr);
        if (write) begin
            modelWrite(addr, data, strb);
        end
        steps.push_back(s);
    endtask

    task automatic readBackAll(string tag);
        for (int i = 0; i < NumRegs; i++) begin
            addStep($sformatf("%s read 0x%06h", tag, regAddrs[i]), 1'b0, regAddrs[i], '0, '0);
        end
    endtask

    task automatic checkValue(string name, apbData_t expected, apbData_t actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("Fail %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic apbTransfer(input logic write, input apbAddr_t addr, input apbData_t data,
                               input apbStrb_t strb, output apbData_t rdata,
                               output logic err, output logic done);
        int waitCycles;
        rdata = '0;
        err   = 1'b0;
        done  = 1'b0;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= write;
        pwdata  <= data;
        pstrb   <= strb;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        waitCycles = 0;
        // Response sampled in the middle of the cycle
        while (!done && waitCycles < ReadyTimeout) begin
            @(negedge clk);
            if (pready) begin
                done  = 1'b1;
                rdata = prdata;
                err   = pslverr;
            end
            waitCycles++;
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        if (!done) begin
            errorCount++;
            $display("Error: no pready within timeout at address 0x%06h", addr);
        end
    endtask

    task automatic runSteps();
        apbData_t rdata;
        logic     err;
        logic     done;
        foreach (steps[i]) begin
            apbTransfer(steps[i].write, steps[i].addr, steps[i].data, steps[i].strb,
                        rdata, err, done);
            if (done) begin
                checkValue({steps[i].name, " prdata"}, steps[i].expData, rdata);
                checkValue({steps[i].name, " pslverr"}, apbData_t'(steps[i].expErr),
                           apbData_t'(err));
            end
        end
        steps.delete();
    endtask

    task automatic checkOutputs(string tag);
        apbData_t ramCtrl;
        ramCtrl = modelRead(RamCtrlAddr);
        @(negedge clk);
        checkValue({tag, " dbgMuxSel"}, modelRead(MuxSelAddr), dbgMuxSel);
        checkValue({tag, " dstControl"}, modelRead(DstCtrlAddr), dstControl);
        checkValue({tag, " traceRamMode"}, apbData_t'(ramCtrl[0]), apbData_t'(traceRamMode));
        checkValue({tag, " traceRamStart"}, modelRead(StartLowAddr), traceRamStart);
        checkValue({tag, " traceRamLimit"}, modelRead(LimitLowAddr), traceRamLimit);
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        pstrb      = '0;
        errorCount = 0;
        checkCount = 0;
        void'($urandom(SeedValue));
        foreach (modelRegs[i]) begin
            modelRegs[i] = '0;
        end
        repeat (ResetCycles) @(posedge clk);
        reset <= 1'b0;

        readBackAll("reset");
        runSteps();
        checkOutputs("reset");

        // Byte strobe merges on MCR, DST and scratch
        addStep("mux sel full", 1'b1, MuxSelAddr, 32'hA5A5_1234, 4'hF);
        addStep("dfd csr bytes 0 and 2", 1'b1, DfdCsrAddr, 32'h1122_3344, 4'h5);
        addStep("dst control low half", 1'b1, DstCtrlAddr, 32'hCAFE_BEEF, 4'h3);
        addStep("dst cfg high half", 1'b1, DstCfgAddr, 32'h7788_99AA, 4'hC);
        addStep("impl write", 1'b1, DstImplAddr, 32'hFFFF_FFFF, 4'hF);
        addStep("scratch lo", 1'b1, ScrLoAddr, $urandom(), apbStrb_t'($urandom_range(15, 1)));
        addStep("scratch hi", 1'b1, ScrHiAddr, $urandom(), 4'hF);
        addStep("mux sel byte 1", 1'b1, MuxSelAddr, 32'h0000_5A00, 4'h2);
        readBackAll("csr");
        runSteps();
        checkOutputs("csr");

        // SRAM mode clamps
        addStep("start low clamp", 1'b1, StartLowAddr, 32'h0001_2345, 4'hF);
        addStep("start low clamp read", 1'b0, StartLowAddr, '0, '0);
        addStep("limit low legal", 1'b1, LimitLowAddr, 32'h0000_4000, 4'hF);
        addStep("start low legal", 1'b1, StartLowAddr, 32'h0000_7FF0, 4'hF);
        addStep("limit low merge clamp", 1'b1, LimitLowAddr, 32'h00FF_0000, 4'h4);
        addStep("start high sram", 1'b1, StartHighAddr, 32'h0000_DEAD, 4'hF);
        addStep("limit high sram", 1'b1, LimitHighAddr, 32'h0000_BEEF, 4'hF);
        readBackAll("sram");
        runSteps();
        checkOutputs("sram");

        // System memory mode stores as written
        addStep("ram mode sysmem", 1'b1, RamCtrlAddr, 32'h0000_0001, 4'h1);
        addStep("start high sysmem", 1'b1, StartHighAddr, 32'h0000_DEAD, 4'hF);
        addStep("limit high sysmem", 1'b1, LimitHighAddr, 32'h0000_BEEF, 4'hF);
        addStep("start low no clamp", 1'b1, StartLowAddr, 32'h0012_0000, 4'hC);
        addStep("limit low no clamp", 1'b1, LimitLowAddr, 32'h9000_0000, 4'h8);
        readBackAll("sysmem");
        runSteps();
        checkOutputs("sysmem");

        // Unclaimed addresses
        addStep("mcr hole read", 1'b0, 23'h00_0004, '0, '0);
        addStep("mcr hole write", 1'b1, 23'h00_0004, 32'hFFFF_FFFF, 4'hF);
        addStep("dst hole write", 1'b1, 23'h00_200C, 32'h1234_5678, 4'hF);
        addStep("tr hole read", 1'b0, 23'h00_4020, '0, '0);
        addStep("gap write", 1'b1, 23'h00_1000, 32'h5555_AAAA, 4'hF);
        addStep("above map read", 1'b0, 23'h00_6000, '0, '0);
        addStep("top write", 1'b1, 23'h7F_F000, 32'h0BAD_F00D, 4'hF);
        readBackAll("error");
        runSteps();
        checkOutputs("error");

        // Bound assertion failures count as errors too
        errorCount += i_dfdMmrs.i_dfdMmrsProperties.failCount;

        $display("Finished %0d checks with %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
src/dfdCsrPkg.sv
src/dfdMapPkg.sv
src/dfdApbDecode.sv
src/dfdCtrlCsrs.sv
src/dfdTraceRamCsrs.sv
src/dfdReadReturn.sv
src/dfdMmrs.sv
dv/dfdMmrs_properties.sv
dv/dfdMmrsTb.sv

/* Makefile */
# Verilator build and run of the debug register block testbench

VERILATOR ?= verilator
TOP       ?= dfdMmrsTb
FLIST     ?= flist.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	elif ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
